//--- uart_mmio.f
design/uart_mmio_pkg.sv
design/byte_fifo.sv
design/uart_transmitter.sv
design/uart_receiver.sv
design/mmio_regs.sv
design/uart_mmio.sv
dv/uart_mmio_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the uart_mmio testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

rm -rf "$BUILD_DIR"

verilator --binary --timing --assert -Wno-fatal \
  --top-module uart_mmio_tb \
  -f uart_mmio.f \
  --Mdir "$BUILD_DIR" -o sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
  exit 0
else
  echo "Pass line not found in $LOG"
  exit 1
fi

//--- dv/uart_mmio_tb.sv
`timescale 1ns/1ns

module uart_mmio_tb
  import uart_mmio_pkg::*;
();
  localparam int CLOCK_FREQ    = 1_000_000;
  localparam int BAUD_RATE     = 125_000;
  localparam int FIFO_LOGDEPTH = 5;
  localparam int BIT_CYCLES    = CLOCK_FREQ / BAUD_RATE;  // 8 clocks per bit
  localparam int CLK_PERIOD    = 4;
  localparam int DRIVE_DLY     = 1;
  localparam int LOOP_BYTES    = 20;
  localparam int BP_WRITES     = 40;
  localparam int MARGIN_NS     = 20_000;
  localparam int WATCHDOG_NS   =
    (LOOP_BYTES + BP_WRITES) * 10 * BIT_CYCLES * CLK_PERIOD * 4 + MARGIN_NS;

  logic      clk;
  logic      arst_n;
  mmio_req_t req;
  logic      req_valid;
  logic      req_ready;
  mmio_rsp_t rsp;
  logic      rsp_valid;
  logic      serial_in;
  logic      serial_out;
  logic      loopback;

  logic [BYTE_W-1:0] line_q[$];      // Bytes decoded from serial_out
  logic [BYTE_W-1:0] tx_model_q[$];  // Accepted TX bytes not yet matched on the line
  logic [BYTE_W-1:0] rx_model_q[$];  // Bytes expected back through RX_DATA
  int unsigned       cycle_no = 0;
  int unsigned       acc_cycle;      // Cycle of the last accepted request

  assign serial_in = loopback ? serial_out : 1'b1;  // Line idles high when cut

  uart_mmio #(
    .CLOCK_FREQ    (CLOCK_FREQ),
    .BAUD_RATE     (BAUD_RATE),
    .FIFO_LOGDEPTH (FIFO_LOGDEPTH)
  ) u_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .rsp        (rsp),
    .rsp_valid  (rsp_valid),
    .serial_in  (serial_in),
    .serial_out (serial_out)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle_no <= cycle_no + 1;

  task automatic compare_values(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "stopping at first error");
    end
  endtask

  // Waits n cycles, ends at the drive point
  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
    #DRIVE_DLY;
  endtask

  // One request held until accepted, starts and ends at the drive point
  task automatic bus_access(input logic [ADDR_W-1:0] addr, input logic we,
                            input logic [DATA_W-1:0] wdata,
                            output logic [DATA_W-1:0] rdata);
    req.addr  = addr;
    req.we    = we;
    req.wdata = wdata;
    req_valid = 1'b1;
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    acc_cycle = cycle_no;
    @(posedge clk);
    #DRIVE_DLY;
    req_valid = 1'b0;
    @(negedge clk);
    compare_values("rsp_valid after accept", 32'd1, 32'(rsp_valid));
    rdata = rsp.rdata;
    if (we) compare_values("write rdata", 32'd0, rdata);
    @(posedge clk);
    #DRIVE_DLY;
    compare_values("rsp_valid one cycle", 32'd0, 32'(rsp_valid));
  endtask

  task automatic poll_status(input int bit_pos);
    logic [DATA_W-1:0] status;
    bus_access(ADDR_STATUS, 1'b0, '0, status);
    while (!status[bit_pos]) bus_access(ADDR_STATUS, 1'b0, '0, status);
  endtask

  // Line bytes must match accepted TX bytes in order
  task automatic match_line(input string name);
    logic [BYTE_W-1:0] exp_b;
    logic [BYTE_W-1:0] got_b;
    while (line_q.size() < tx_model_q.size()) idle_cycles(1);
    while (tx_model_q.size() > 0) begin
      exp_b = tx_model_q.pop_front();
      got_b = line_q.pop_front();
      compare_values(name, 32'(exp_b), 32'(got_b));
    end
    compare_values({name, " extra bytes"}, 32'd0, 32'(line_q.size()));
  endtask

  function automatic bit is_mapped(input logic [ADDR_W-1:0] addr);
    return addr inside {ADDR_STATUS, ADDR_RX_DATA, ADDR_TX_DATA, ADDR_CYCLES, ADDR_CNT_CLEAR};
  endfunction

  // Serial-line monitor, samples near each bit middle on the falling clock
  initial begin
    logic [BYTE_W-1:0] b;
    wait (arst_n === 1'b1);
    forever begin
      @(negedge serial_out);
      repeat (BIT_CYCLES / 2) @(negedge clk);
      compare_values("start bit", 32'd0, 32'(serial_out));
      for (int i = 0; i < BYTE_W; i++) begin
        repeat (BIT_CYCLES) @(negedge clk);
        b[i] = serial_out;  // LSB first
      end
      repeat (BIT_CYCLES) @(negedge clk);
      compare_values("stop bit", 32'd1, 32'(serial_out));
      line_q.push_back(b);
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int unsigned       seed_val;
    logic [DATA_W-1:0] rdata;
    logic [DATA_W-1:0] c1;
    logic [DATA_W-1:0] c2;
    logic [DATA_W-1:0] c3;
    int unsigned       t1;
    int unsigned       t2;
    logic [BYTE_W-1:0] b;
    logic [ADDR_W-1:0] addr;
    int                n_acc;
    bit                prev_acc;
    bit                stall_seen;

    seed_val  = $urandom(32'hcdb2);
    req       = '0;
    req_valid = 1'b0;
    loopback  = 1'b1;
    arst_n    = 1'b0;
    repeat (10) @(posedge clk);
    #DRIVE_DLY;
    arst_n = 1'b1;
    idle_cycles(1);

    // 1. Reset state
    bus_access(ADDR_STATUS, 1'b0, '0, rdata);
    compare_values("status after reset", 32'h1, rdata);  // tx_ready only
    compare_values("serial_out idle", 32'd1, 32'(serial_out));

    // 2. Loopback
    for (int i = 0; i < LOOP_BYTES; i++) begin
      poll_status(STATUS_TX_READY_BIT);
      b = 8'($urandom_range(0, 255));
      bus_access(ADDR_TX_DATA, 1'b1, DATA_W'(b), rdata);
      tx_model_q.push_back(b);
      rx_model_q.push_back(b);
    end
    while (rx_model_q.size() > 0) begin
      poll_status(STATUS_RX_VALID_BIT);
      bus_access(ADDR_RX_DATA, 1'b0, '0, rdata);
      b = rx_model_q.pop_front();
      compare_values("loopback rx byte", DATA_W'(b), rdata);
    end
    match_line("loopback line byte");

    // 3. Back-pressure, writes held back to back on a cut line
    loopback   = 1'b0;
    n_acc      = 0;
    prev_acc   = 1'b0;
    stall_seen = 1'b0;
    req.addr   = ADDR_TX_DATA;
    req.we     = 1'b1;
    req.wdata  = DATA_W'($urandom_range(0, 255));
    req_valid  = 1'b1;
    while (n_acc < BP_WRITES) begin
      @(negedge clk);
      compare_values("bp rsp_valid", 32'(prev_acc), 32'(rsp_valid));
      if (rsp_valid) compare_values("bp write rdata", 32'd0, rsp.rdata);
      if (!req_ready && !stall_seen) begin
        stall_seen = 1'b1;
        // FIFO entries plus the byte held by the transmitter
        compare_values("bp first stall", 32'((1 << FIFO_LOGDEPTH) + 1), 32'(n_acc));
      end
      prev_acc = req_ready;
      if (req_ready) begin
        tx_model_q.push_back(req.wdata[BYTE_W-1:0]);
        n_acc++;
      end
      @(posedge clk);
      #DRIVE_DLY;
      if (prev_acc) begin
        if (n_acc < BP_WRITES) req.wdata = DATA_W'($urandom_range(0, 255));
        else                   req_valid = 1'b0;
      end
    end
    compare_values("bp stall seen", 32'd1, 32'(stall_seen));
    @(negedge clk);
    compare_values("bp last rsp_valid", 32'd1, 32'(rsp_valid));
    idle_cycles(1);
    // Last stalled write refilled the FIFO
    bus_access(ADDR_STATUS, 1'b0, '0, rdata);
    compare_values("bp status full", 32'd0, 32'(rdata[STATUS_TX_READY_BIT]));
    match_line("bp line byte");

    // 4. Cycle counter
    bus_access(ADDR_CYCLES, 1'b0, '0, c1);
    t1 = acc_cycle;
    idle_cycles($urandom_range(1, 20));
    bus_access(ADDR_CYCLES, 1'b0, '0, c2);
    t2 = acc_cycle;
    compare_values("cycles increase", 32'd1, 32'(c2 > c1));
    compare_values("cycles step", t2 - t1, c2 - c1);
    bus_access(ADDR_CNT_CLEAR, 1'b1, DATA_W'($urandom), rdata);
    t1 = acc_cycle;
    idle_cycles($urandom_range(1, 20));
    bus_access(ADDR_CYCLES, 1'b0, '0, c3);
    compare_values("cycles after clear smaller", 32'd1, 32'(c3 < c2));
    compare_values("cycles since clear", acc_cycle - t1 - 1, c3);  // Zero the cycle after

    // 5. Empty and unmapped reads
    bus_access(ADDR_STATUS, 1'b0, '0, rdata);
    compare_values("rx empty status", 32'd0, 32'(rdata[STATUS_RX_VALID_BIT]));
    bus_access(ADDR_RX_DATA, 1'b0, '0, rdata);
    compare_values("rx empty read", 32'd0, rdata);
    addr = 8'($urandom);
    while (is_mapped(addr)) addr = 8'($urandom);
    bus_access(addr, 1'b0, '0, rdata);
    compare_values("unmapped read", 32'd0, rdata);

    $display("TEST OK");
    $finish;
  end

endmodule

//--- design/uart_mmio.sv
`timescale 1ns/1ns

module uart_mmio
  import uart_mmio_pkg::*;
#(
  parameter int CLOCK_FREQ    = 50_000_000,
  parameter int BAUD_RATE     = 115_200,
  parameter int FIFO_LOGDEPTH = 5
) (
  input  logic      clk,
  input  logic      arst_n,
  input  mmio_req_t req,
  input  logic      req_valid,
  output logic      req_ready,
  output mmio_rsp_t rsp,
  output logic      rsp_valid,
  input  logic      serial_in,
  output logic      serial_out
);
  // Register block to TX FIFO to transmitter
  logic [BYTE_W-1:0] tx_enq_data;
  logic              tx_enq_valid;
  logic              tx_enq_ready;
  logic [BYTE_W-1:0] tx_deq_data;
  logic              tx_deq_valid;
  logic              tx_deq_ready;

  // Receiver to RX FIFO to register block
  logic [BYTE_W-1:0] rx_enq_data;
  logic              rx_enq_valid;
  logic              rx_enq_ready;
  logic [BYTE_W-1:0] rx_deq_data;
  logic              rx_deq_valid;
  logic              rx_deq_ready;

  mmio_regs u_regs (
    .clk       (clk),
    .arst_n    (arst_n),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .tx_data   (tx_enq_data),
    .tx_valid  (tx_enq_valid),
    .tx_ready  (tx_enq_ready),
    .rx_data   (rx_deq_data),
    .rx_valid  (rx_deq_valid),
    .rx_ready  (rx_deq_ready)
  );

  byte_fifo #(
    .WIDTH    (BYTE_W),
    .LOGDEPTH (FIFO_LOGDEPTH)
  ) u_tx_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .enq_data  (tx_enq_data),
    .enq_valid (tx_enq_valid),
    .enq_ready (tx_enq_ready),
    .deq_data  (tx_deq_data),
    .deq_valid (tx_deq_valid),
    .deq_ready (tx_deq_ready)
  );

  uart_transmitter #(
    .CLOCK_FREQ (CLOCK_FREQ),
    .BAUD_RATE  (BAUD_RATE)
  ) u_uart_tx (
    .clk        (clk),
    .arst_n     (arst_n),
    .data       (tx_deq_data),
    .data_valid (tx_deq_valid),
    .data_ready (tx_deq_ready),  // Pops the FIFO when idle
    .serial_out (serial_out)
  );

  uart_receiver #(
    .CLOCK_FREQ (CLOCK_FREQ),
    .BAUD_RATE  (BAUD_RATE)
  ) u_uart_rx (
    .clk        (clk),
    .arst_n     (arst_n),
    .serial_in  (serial_in),
    .data       (rx_enq_data),
    .data_valid (rx_enq_valid),
    .data_ready (rx_enq_ready)
  );

  byte_fifo #(
    .WIDTH    (BYTE_W),
    .LOGDEPTH (FIFO_LOGDEPTH)
  ) u_rx_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .enq_data  (rx_enq_data),
    .enq_valid (rx_enq_valid),
    .enq_ready (rx_enq_ready),
    .deq_data  (rx_deq_data),
    .deq_valid (rx_deq_valid),
    .deq_ready (rx_deq_ready)
  );

endmodule

//--- design/mmio_regs.sv
`timescale 1ns/1ns

module mmio_regs
  import uart_mmio_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  input  mmio_req_t         req,
  input  logic              req_valid,
  output logic              req_ready,
  output mmio_rsp_t         rsp,
  output logic              rsp_valid,
  output logic [BYTE_W-1:0] tx_data,
  output logic              tx_valid,
  input  logic              tx_ready,
  input  logic [BYTE_W-1:0] rx_data,
  input  logic              rx_valid,
  output logic              rx_ready
);
  logic              accept;
  logic              is_tx_wr;
  logic              is_rx_rd;
  logic              cnt_clear;
  logic [DATA_W-1:0] status;
  logic [DATA_W-1:0] rdata_next;
  logic [DATA_W-1:0] cycles;

  assign is_tx_wr = req.we && (req.addr == ADDR_TX_DATA);
  assign is_rx_rd = !req.we && (req.addr == ADDR_RX_DATA);

  // Stall only a TX write that finds the FIFO full
  assign req_ready = !(req_valid && is_tx_wr && !tx_ready);
  assign accept    = req_valid && req_ready;

  assign tx_data   = req.wdata[BYTE_W-1:0];
  assign tx_valid  = accept && is_tx_wr;
  assign rx_ready  = accept && is_rx_rd && rx_valid;  // Pop only a real byte
  assign cnt_clear = accept && req.we && (req.addr == ADDR_CNT_CLEAR);

  always_comb begin
    status = '0;
    status[STATUS_TX_READY_BIT] = tx_ready;
    status[STATUS_RX_VALID_BIT] = rx_valid;
  end

  // Read mux, writes and unmapped offsets give zero
  always_comb begin
    rdata_next = '0;
    if (!req.we) begin
      case (req.addr)
        ADDR_STATUS:  rdata_next = status;
        ADDR_RX_DATA: rdata_next = rx_valid ? DATA_W'(rx_data) : '0;
        ADDR_CYCLES:  rdata_next = cycles;
        default:      rdata_next = '0;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)        cycles <= '0;
    else if (cnt_clear) cycles <= '0;
    else                cycles <= cycles + 1'b1;  // Free running, wraps
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) rsp_valid <= 1'b0;
    else         rsp_valid <= accept;
  end

  always_ff @(posedge clk) begin
    rsp.rdata <= rdata_next;
  end

  // Writes answer with zero data
  a_rsp_timing: assert property (@(posedge clk) disable iff (!arst_n)
    accept |=> rsp_valid && (!$past(req.we) || rsp.rdata == '0));

  // RX FIFO must not be popped when empty
  a_rx_pop: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(rx_ready) |-> rx_valid);

endmodule

//--- design/uart_receiver.sv
`timescale 1ns/1ns

module uart_receiver
  import uart_mmio_pkg::*;
#(
  parameter int CLOCK_FREQ = 50_000_000,
  parameter int BAUD_RATE  = 115_200
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              serial_in,
  output logic [BYTE_W-1:0] data,
  output logic              data_valid,
  input  logic              data_ready
);
  localparam int CLOCKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
  localparam int CNT_W          = $clog2(CLOCKS_PER_BIT + 1);
  localparam int FRAME_BITS     = BYTE_W + 2;
  localparam int BIT_W          = $clog2(FRAME_BITS);

  logic [1:0]        sync;
  logic              rx;
  logic              busy;
  logic [CNT_W-1:0]  clk_cnt;  // Counts down to the next bit middle
  logic [BIT_W-1:0]  bit_cnt;
  logic [BYTE_W-1:0] shift;
  logic              sample;
  logic              stop_bit;
  logic              frame_done;

  assign rx         = sync[1];
  assign sample     = busy && (clk_cnt == '0);
  assign stop_bit   = (bit_cnt == BIT_W'(FRAME_BITS - 1));
  assign frame_done = sample && stop_bit && rx;  // Framing errors are dropped

  // Two-flop synchronizer, idles high
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) sync <= 2'b11;
    else         sync <= {sync[0], serial_in};
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else if (!busy) begin
      if (!rx) begin
        // Start edge, aim at the middle of the start bit
        busy    <= 1'b1;
        clk_cnt <= CNT_W'(CLOCKS_PER_BIT / 2 - 1);
        bit_cnt <= '0;
      end
    end else if (sample) begin
      clk_cnt <= CNT_W'(CLOCKS_PER_BIT - 1);
      bit_cnt <= bit_cnt + 1'b1;
      if ((bit_cnt == '0 && rx) || stop_bit) begin
        busy <= 1'b0;  // Glitch on the start bit, or frame over
      end
    end else begin
      clk_cnt <= clk_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (sample && bit_cnt != '0 && !stop_bit) begin
      shift <= {rx, shift[BYTE_W-1:1]};
    end
    if (frame_done) data <= shift;  // Newer byte replaces an unclaimed one
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)         data_valid <= 1'b0;
    else if (frame_done) data_valid <= 1'b1;
    else if (data_ready) data_valid <= 1'b0;
  end

  a_data_held: assert property (@(posedge clk) disable iff (!arst_n)
    data_valid && !data_ready && !frame_done |=> $stable(data));

endmodule

//--- design/uart_transmitter.sv
`timescale 1ns/1ns

module uart_transmitter
  import uart_mmio_pkg::*;
#(
  parameter int CLOCK_FREQ = 50_000_000,
  parameter int BAUD_RATE  = 115_200
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [BYTE_W-1:0] data,
  input  logic              data_valid,
  output logic              data_ready,
  output logic              serial_out
);
  localparam int CLOCKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
  localparam int CNT_W          = $clog2(CLOCKS_PER_BIT + 1);
  localparam int FRAME_BITS     = BYTE_W + 2;  // Start, data, stop
  localparam int BIT_W          = $clog2(FRAME_BITS);

  logic [FRAME_BITS-1:0] shift;
  logic [BIT_W-1:0]      bit_cnt;
  logic [CNT_W-1:0]      clk_cnt;
  logic                  busy;
  logic                  bit_end;

  assign data_ready = !busy;
  assign serial_out = shift[0];  // All ones while idle
  assign bit_end    = (clk_cnt == CNT_W'(CLOCKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy    <= 1'b0;
      shift   <= '1;
      bit_cnt <= '0;
      clk_cnt <= '0;
    end else if (!busy) begin
      if (data_valid) begin
        busy    <= 1'b1;
        shift   <= {1'b1, data, 1'b0};  // LSB first after the start bit
        bit_cnt <= '0;
        clk_cnt <= '0;
      end
    end else if (bit_end) begin
      // Next bit, ones shift in behind the frame
      shift   <= {1'b1, shift[FRAME_BITS-1:1]};
      clk_cnt <= '0;
      bit_cnt <= bit_cnt + 1'b1;
      if (bit_cnt == BIT_W'(FRAME_BITS - 1)) begin
        busy <= 1'b0;  // Stop bit done
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

endmodule

//--- design/byte_fifo.sv
`timescale 1ns/1ns

module byte_fifo
  import uart_mmio_pkg::*;
#(
  parameter int WIDTH    = BYTE_W,
  parameter int LOGDEPTH = 5
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic [WIDTH-1:0] enq_data,
  input  logic             enq_valid,
  output logic             enq_ready,
  output logic [WIDTH-1:0] deq_data,
  output logic             deq_valid,
  input  logic             deq_ready
);
  localparam int DEPTH = 1 << LOGDEPTH;

  logic [WIDTH-1:0]  mem [DEPTH];
  logic [LOGDEPTH:0] wr_ptr;  // Top bit is the wrap flag
  logic [LOGDEPTH:0] rd_ptr;
  logic              full;
  logic              empty;
  logic              do_enq;
  logic              do_deq;

  // Same slot, different lap
  assign full  = (wr_ptr ^ rd_ptr) == {1'b1, {LOGDEPTH{1'b0}}};
  assign empty = (wr_ptr == rd_ptr);

  assign enq_ready = !full;
  assign deq_valid = !empty;
  assign deq_data  = mem[rd_ptr[LOGDEPTH-1:0]];

  assign do_enq = enq_valid && enq_ready;
  assign do_deq = deq_valid && deq_ready;

  always_ff @(posedge clk) begin
    if (do_enq) mem[wr_ptr[LOGDEPTH-1:0]] <= enq_data;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_enq) wr_ptr <= wr_ptr + 1'b1;
      if (do_deq) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Pointers must not move past each other
  a_no_write_full: assert property (@(posedge clk) disable iff (!arst_n)
    full |=> $stable(wr_ptr));

  a_no_read_empty: assert property (@(posedge clk) disable iff (!arst_n)
    empty |=> $stable(rd_ptr));

endmodule

//--- design/uart_mmio_pkg.sv
package uart_mmio_pkg;

  // Bus and UART widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 8;  // Byte offset within the block
  localparam int BYTE_W = 8;

  // Register map, byte offsets
  localparam logic [ADDR_W-1:0] ADDR_STATUS    = 8'h00;
  localparam logic [ADDR_W-1:0] ADDR_RX_DATA   = 8'h04;
  localparam logic [ADDR_W-1:0] ADDR_TX_DATA   = 8'h08;
  localparam logic [ADDR_W-1:0] ADDR_CYCLES    = 8'h10;
  localparam logic [ADDR_W-1:0] ADDR_CNT_CLEAR = 8'h18;

  // Status word layout
  localparam int STATUS_TX_READY_BIT = 0;  // TX FIFO has room
  localparam int STATUS_RX_VALID_BIT = 1;  // RX FIFO holds a byte

  // One 32-bit access
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              we;
  } mmio_req_t;

  // Read data, zero for writes
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
  } mmio_rsp_t;

endpackage
